/* Makefile */
TOP := divider_signed_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f divider_signed.f --top-module $(TOP)

sim:
	rm -f sim.log
	verilator --binary --timing --assert -f divider_signed.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* divider_signed.f */
+incdir+src
src/div_pkg.sv
src/div_control_fsm.sv
src/div_step_counter.sv
src/div_divisor_shifter.sv
src/div_remainder_unit.sv
src/div_quotient_unit.sv
src/divider_signed.sv
tb/divider_signed_properties.sv
tb/divider_signed_tb.sv

/* src/div_control_fsm.sv */
`timescale 1ns/1ps

module div_control_fsm (
    input  logic               clock,
    input  logic               reset,
    input  logic               in_valid,
    output logic               in_ready,
    output logic               out_valid,
    input  logic               out_ready,
    input  logic               last_step,
    output div_pkg::div_ctrl_t ctrl
);
    import div_pkg::*;

    div_state_t state;
    div_state_t next_state;

    // events built from state and handshake, used instead of raw states below
    logic load_inputs;
    logic read_outputs;
    logic calculating;
    logic last_calculation;

    // ready and valid depend on the state only
    // no combinational path from one handshake side to the other
    always_comb begin
        in_ready  = (state == STATE_LOAD);
        out_valid = (state == STATE_DONE);
    end

    always_comb begin
        // operands written in on this edge
        load_inputs      = in_ready && in_valid;
        // result taken on this edge
        read_outputs     = out_valid && out_ready;
        // one division step per cycle while calculating
        calculating      = (state == STATE_CALC);
        last_calculation = calculating && last_step;
    end

    // the events are exclusive, each one only exists in its own state
    always_comb begin
        next_state = state;
        if (load_inputs) begin
            next_state = STATE_CALC;
        end
        if (last_calculation) begin
            next_state = STATE_DONE;
        end
        if (read_outputs) begin
            next_state = STATE_LOAD;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= STATE_LOAD;
        end else begin
            state <= next_state;
        end
    end

    // fan the events out to the counter and the data path
    always_comb begin
        ctrl.load = load_inputs;
        ctrl.step = calculating;
    end

endmodule

/* src/div_divisor_shifter.sv */
`timescale 1ns/1ps
`include "div_params.svh"

module div_divisor_shifter (
    input  logic                clock,
    input  logic                reset,
    input  div_pkg::div_ctrl_t  ctrl,
    input  div_pkg::word_t      divisor,
    output logic                divisor_sign,
    output logic                divide_by_zero,
    output div_pkg::word_long_t increment,
    output logic                increment_valid
);
    import div_pkg::*;

    localparam int MSB = `DIV_WORD_WIDTH_LONG - 1;

    word_long_t divisor_long;
    word_long_t divisor_shifted;
    logic       divisor_all_sign_bits;

    // sign-extend by the guard bit
    always_comb begin
        divisor_long = {divisor[`DIV_WORD_WIDTH-1], divisor};
    end

    // sign and zero flag are captured once per division
    always_ff @(posedge clock) begin
        if (reset) begin
            divisor_sign   <= 1'b0;
            divide_by_zero <= 1'b0;
        end else if (ctrl.load) begin
            divisor_sign   <= divisor_long[MSB];
            divide_by_zero <= (divisor_long == '0);
        end
    end

    // divisor drains right one bit per step, arithmetic shift keeps the sign
    // its low bit enters the top of the increment, so the increment builds up
    // as divisor * 2^k with k falling by one each step
    // the load itself already does the first shift
    always_ff @(posedge clock) begin
        if (ctrl.load) begin
            divisor_shifted <= {divisor_long[MSB], divisor_long[MSB:1]};
            increment       <= {divisor_long[0], {`DIV_WORD_WIDTH{1'b0}}};
        end else if (ctrl.step) begin
            divisor_shifted <= {divisor_shifted[MSB], divisor_shifted[MSB:1]};
            increment       <= {divisor_shifted[0], increment[MSB:1]};
        end
    end

    // non-sign bits left in the divisor means the increment is out of range
    always_comb begin
        divisor_all_sign_bits = (divisor_shifted == {`DIV_WORD_WIDTH_LONG{divisor_sign}});
    end

    // the increment also needs enough bits shifted in to carry the divisor sign
    always_comb begin
        increment_valid = divisor_all_sign_bits && (increment[MSB] == divisor_sign);
    end

endmodule

/* src/div_params.svh */
`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// operand and result width
`define DIV_WORD_WIDTH 8

// one guard bit more, so the most negative dividend can still be reduced
// (e.g. -128 / 1 has to remove +128 from the remainder)
`define DIV_WORD_WIDTH_LONG (`DIV_WORD_WIDTH + 1)

// bits needed to hold the initial step count, DIV_WORD_WIDTH_LONG - 1
`define DIV_STEPS_WIDTH $clog2(`DIV_WORD_WIDTH_LONG)

`endif

/* src/div_pkg.sv */
`include "div_params.svh"

package div_pkg;

    // operand or result word
    typedef logic [`DIV_WORD_WIDTH-1:0] word_t;

    // internal remainder, increment and quotient, with the guard bit
    typedef logic [`DIV_WORD_WIDTH_LONG-1:0] word_long_t;

    // division step count
    typedef logic [`DIV_STEPS_WIDTH-1:0] step_t;

    // load -> calc -> done -> load
    typedef enum logic [1:0] {
        STATE_LOAD = 2'b00,
        STATE_CALC = 2'b01,
        STATE_DONE = 2'b10
    } div_state_t;

    // control events shared by the counter and the data units
    typedef struct packed {
        logic load;
        logic step;
    } div_ctrl_t;

    typedef struct packed {
        word_t dividend;
        word_t divisor;
    } div_operands_t;

    typedef struct packed {
        word_t quotient;
        word_t remainder;
        logic  divide_by_zero;
    } div_result_t;

endpackage

/* src/div_quotient_unit.sv */
`timescale 1ns/1ps
`include "div_params.svh"

module div_quotient_unit (
    input  logic               clock,
    input  logic               reset,
    input  div_pkg::div_ctrl_t ctrl,
    input  logic               signs_differ,
    input  logic               step_valid,
    output div_pkg::word_t     quotient
);
    import div_pkg::*;

    // weight of the first step, matching the increment at divisor * 2^(W_L-1)
    localparam word_long_t INCREMENT_TOP = word_long_t'(1) << (`DIV_WORD_WIDTH_LONG - 1);

    word_long_t quotient_increment;
    word_long_t quotient_long;
    word_long_t quotient_next;

    // one-hot weight, halves on every step whether or not the step is taken
    always_ff @(posedge clock) begin
        if (reset) begin
            quotient_increment <= '0;
        end else if (ctrl.load) begin
            quotient_increment <= INCREMENT_TOP;
        end else if (ctrl.step) begin
            quotient_increment <= quotient_increment >> 1;
        end
    end

    // opposite operand signs give a negative quotient
    always_comb begin
        quotient_next = signs_differ ? (quotient_long - quotient_increment)
                                     : (quotient_long + quotient_increment);
    end

    always_ff @(posedge clock) begin
        if (ctrl.load) begin
            quotient_long <= '0;
        end else if (step_valid) begin
            quotient_long <= quotient_next;
        end
    end

    // low bits only, so -128 / -1 wraps to -128
    // and a zero divisor leaves -1 or 1 here
    always_comb begin
        quotient = quotient_long[`DIV_WORD_WIDTH-1:0];
    end

endmodule

/* src/div_remainder_unit.sv */
`timescale 1ns/1ps
`include "div_params.svh"

module div_remainder_unit (
    input  logic                clock,
    input  logic                reset,
    input  div_pkg::div_ctrl_t  ctrl,
    input  div_pkg::word_t      dividend,
    input  logic                divisor_sign,
    input  div_pkg::word_long_t increment,
    input  logic                increment_valid,
    output logic                signs_differ,
    output logic                step_valid,
    output div_pkg::word_t      remainder
);
    import div_pkg::*;

    localparam int MSB = `DIV_WORD_WIDTH_LONG - 1;

    word_long_t dividend_long;
    word_long_t remainder_long;
    word_long_t remainder_next;
    logic       dividend_sign;
    logic       remainder_overshoot;

    always_comb begin
        dividend_long = {dividend[`DIV_WORD_WIDTH-1], dividend};
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            dividend_sign <= 1'b0;
        end else if (ctrl.load) begin
            dividend_sign <= dividend_long[MSB];
        end
    end

    // move the remainder toward zero
    // add when signs differ, subtract otherwise
    always_comb begin
        signs_differ   = (divisor_sign != dividend_sign);
        remainder_next = signs_differ ? (remainder_long + increment)
                                      : (remainder_long - increment);
    end

    // crossing past zero removes too much, the step is skipped then
    // landing exactly on zero is fine, needed for a negative dividend
    always_comb begin
        remainder_overshoot = (remainder_next[MSB] != dividend_sign)
                           && (remainder_next != '0);
        step_valid          = ctrl.step && increment_valid && !remainder_overshoot;
    end

    // dividend becomes the remainder and shrinks on valid steps
    always_ff @(posedge clock) begin
        if (ctrl.load) begin
            remainder_long <= dividend_long;
        end else if (step_valid) begin
            remainder_long <= remainder_next;
        end
    end

    // guard bit dropped, always fits since |remainder| <= |dividend|
    always_comb begin
        remainder = remainder_long[`DIV_WORD_WIDTH-1:0];
    end

endmodule

/* src/div_step_counter.sv */
`timescale 1ns/1ps
`include "div_params.svh"

module div_step_counter (
    input  logic               clock,
    input  logic               reset,
    input  div_pkg::div_ctrl_t ctrl,
    output logic               last_step
);
    import div_pkg::*;

    // WORD_WIDTH_LONG steps in all, counting down to zero
    localparam step_t STEPS_INITIAL = step_t'(`DIV_WORD_WIDTH_LONG - 1);
    localparam step_t STEPS_ZERO    = '0;
    localparam step_t STEPS_ONE     = step_t'(1);

    step_t count;

    // reload on every new division, hold at zero once reached
    always_ff @(posedge clock) begin
        if (reset || ctrl.load) begin
            count <= STEPS_INITIAL;
        end else if (ctrl.step && (count != STEPS_ZERO)) begin
            count <= count - STEPS_ONE;
        end
    end

    // zero means the step in progress is the final one
    always_comb begin
        last_step = (count == STEPS_ZERO);
    end

endmodule

/* src/divider_signed.sv */
`timescale 1ns/1ps

module divider_signed (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   in_valid,
    output logic                   in_ready,
    input  div_pkg::div_operands_t operands,
    output logic                   out_valid,
    input  logic                   out_ready,
    output div_pkg::div_result_t   result
);
    import div_pkg::*;

    div_ctrl_t  ctrl;
    logic       last_step;

    // divisor side to remainder side
    logic       divisor_sign;
    word_long_t increment;
    logic       increment_valid;

    // remainder side to quotient side
    logic       signs_differ;
    logic       step_valid;

    word_t      quotient;
    word_t      remainder;
    logic       divide_by_zero;

    div_control_fsm u_control_fsm (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .last_step (last_step),
        .ctrl      (ctrl)
    );

    div_step_counter u_step_counter (
        .clock     (clock),
        .reset     (reset),
        .ctrl      (ctrl),
        .last_step (last_step)
    );

    div_divisor_shifter u_divisor_shifter (
        .clock           (clock),
        .reset           (reset),
        .ctrl            (ctrl),
        .divisor         (operands.divisor),
        .divisor_sign    (divisor_sign),
        .divide_by_zero  (divide_by_zero),
        .increment       (increment),
        .increment_valid (increment_valid)
    );

    div_remainder_unit u_remainder_unit (
        .clock           (clock),
        .reset           (reset),
        .ctrl            (ctrl),
        .dividend        (operands.dividend),
        .divisor_sign    (divisor_sign),
        .increment       (increment),
        .increment_valid (increment_valid),
        .signs_differ    (signs_differ),
        .step_valid      (step_valid),
        .remainder       (remainder)
    );

    div_quotient_unit u_quotient_unit (
        .clock        (clock),
        .reset        (reset),
        .ctrl         (ctrl),
        .signs_differ (signs_differ),
        .step_valid   (step_valid),
        .quotient     (quotient)
    );

    // registers hold through back-pressure, so the result is stable while valid
    assign result = '{quotient: quotient, remainder: remainder, divide_by_zero: divide_by_zero};

endmodule

/* tb/divider_signed_properties.sv */
`timescale 1ns/1ps

module divider_signed_properties (
    input logic                 clock,
    input logic                 reset,
    input logic                 in_ready,
    input logic                 out_valid,
    input logic                 out_ready,
    input div_pkg::div_result_t result
);

    // load and done are different states, so ready and valid never overlap
    ready_valid_exclusive: assert property (
        @(posedge clock) disable iff (reset)
        !(in_ready && out_valid)
    ) else $error("in_ready and out_valid are high together");

    // back-pressure keeps the result offered and unchanged
    result_held: assert property (
        @(posedge clock) disable iff (reset)
        (out_valid && !out_ready) |=> (out_valid && $stable(result))
    ) else $error("result dropped or changed while out_ready was low");

    // machine comes out of reset in the load state
    ready_after_reset: assert property (
        @(posedge clock)
        $fell(reset) |-> in_ready
    ) else $error("in_ready is low on the first cycle after reset");

endmodule

/* tb/divider_signed_tb.sv */
`timescale 1ns/1ps
`include "div_params.svh"

module divider_signed_tb;
    import div_pkg::*;

    localparam int CLOCK_PERIOD = 20;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_RANDOM   = 40;
    localparam int MAX_STALL    = 3;
    // accept edge to out_valid
    localparam int LATENCY      = `DIV_WORD_WIDTH_LONG;
    // offer, accept, steps, stall, ready and handshake edges
    localparam int TEST_CYCLES  = `DIV_WORD_WIDTH_LONG + MAX_STALL + 4;
    localparam int SPARE_CYCLES = 20;

    typedef struct packed {
        word_t       dividend;
        word_t       divisor;
        logic [1:0]  stall;
        div_result_t expected;
    } test_entry_t;

    logic          clock;
    logic          reset;
    logic          in_valid;
    logic          in_ready;
    div_operands_t operands;
    logic          out_valid;
    logic          out_ready;
    div_result_t   result;

    test_entry_t   test_table[$];
    logic [31:0]   lfsr_state;
    logic          table_built;
    int            error_count;
    int            pass_count;
    int            fail_count;

    divider_signed DUT (
        .clock     (clock),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .operands  (operands),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result)
    );

    bind divider_signed divider_signed_properties u_properties (
        .clock     (clock),
        .reset     (reset),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .result    (result)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #(CLOCK_PERIOD / 2) clock = ~clock;
        end
    end

    // galois form, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    // one lfsr step per bit
    task automatic take_random_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // truncating division, low bits kept, zero divisor gives -1 or 1
    function automatic div_result_t model_divide(input word_t dividend, input word_t divisor);
        div_result_t expected;
        int          a;
        int          b;
        a = int'($signed(dividend));
        b = int'($signed(divisor));
        if (b == 0) begin
            expected.quotient       = (a < 0) ? word_t'(1) : word_t'(-1);
            expected.remainder      = dividend;
            expected.divide_by_zero = 1'b1;
        end else begin
            expected.quotient       = word_t'(a / b);
            expected.remainder      = word_t'(a % b);
            expected.divide_by_zero = 1'b0;
        end
        return expected;
    endfunction

    task automatic add_test(input int dividend, input int divisor, input int stall);
        test_entry_t entry;
        entry.dividend = word_t'(dividend);
        entry.divisor  = word_t'(divisor);
        entry.stall    = 2'(stall);
        entry.expected = model_divide(entry.dividend, entry.divisor);
        test_table.push_back(entry);
    endtask

    task automatic build_table();
        logic [31:0] dividend_bits;
        logic [31:0] divisor_bits;
        logic [31:0] stall_bits;
        // sign combinations, small over large
        add_test(22, 7, 0);
        add_test(-22, 7, 1);
        add_test(22, -7, 2);
        add_test(-22, -7, 3);
        add_test(7, 22, 0);
        add_test(-7, -22, 1);
        add_test(-7, 22, 0);
        add_test(7, -22, 2);
        add_test(21, 7, 0);
        add_test(-21, 7, 0);
        add_test(0, 5, 0);
        add_test(0, -5, 1);
        // zero divisor
        add_test(5, 0, 0);
        add_test(-5, 0, 3);
        add_test(0, 0, 0);
        add_test(-128, 0, 1);
        add_test(127, 0, 0);
        // edge values, -128 / -1 wraps
        add_test(-128, -1, 2);
        add_test(-128, 1, 0);
        add_test(127, -1, 1);
        add_test(127, 1, 0);
        add_test(-128, 127, 0);
        add_test(127, -128, 3);
        add_test(-128, -128, 0);
        add_test(-1, 1, 0);
        add_test(100, 3, 2);
        add_test(-100, -3, 0);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            take_random_bits(`DIV_WORD_WIDTH, dividend_bits);
            take_random_bits(`DIV_WORD_WIDTH, divisor_bits);
            take_random_bits(2, stall_bits);
            add_test(int'(dividend_bits[7:0]), int'(divisor_bits[7:0]), int'(stall_bits[1:0]));
        end
    endtask

    function automatic void report_mismatch(input string where, input string name,
                                            input logic [31:0] got, input logic [31:0] expected);
        $display("[ERROR] %s %s: got 0x%0h expected 0x%0h", where, name, got, expected);
        error_count++;
    endfunction

    function automatic void report_failure(input int index, input string what);
        $display("test %0d: %s", index, what);
        error_count++;
    endfunction

    task automatic run_test(input int index);
        test_entry_t entry;
        div_result_t captured;
        string       where;
        int          errors_before;
        int          cycles;
        logic        ready_seen;
        entry         = test_table[index];
        where         = $sformatf("test %0d", index);
        errors_before = error_count;
        ready_seen    = 1'b0;

        // offer the operands and wait for in_ready
        @(posedge clock);
        in_valid <= 1'b1;
        operands <= '{dividend: entry.dividend, divisor: entry.divisor};
        @(negedge clock);
        cycles = 0;
        while (!in_ready && cycles < TEST_CYCLES) begin
            @(negedge clock);
            cycles++;
        end
        if (!in_ready) begin
            report_failure(index, "operands were never accepted");
        end
        // accept edge
        @(posedge clock);
        in_valid <= 1'b0;

        // count edges after the accept edge until out_valid
        @(negedge clock);
        cycles = 0;
        while (!out_valid && cycles < TEST_CYCLES) begin
            if (in_ready && !ready_seen) begin
                report_failure(index, "in_ready went high during the calculation");
                ready_seen = 1'b1;
            end
            @(negedge clock);
            cycles++;
        end
        if (!out_valid) begin
            report_failure(index, "out_valid never rose");
        end else if (cycles != LATENCY) begin
            report_mismatch(where, "latency", 32'(cycles), 32'(LATENCY));
        end

        captured = result;
        if (captured.quotient !== entry.expected.quotient) begin
            report_mismatch(where, "quotient", 32'(captured.quotient),
                            32'(entry.expected.quotient));
        end
        if (captured.remainder !== entry.expected.remainder) begin
            report_mismatch(where, "remainder", 32'(captured.remainder),
                            32'(entry.expected.remainder));
        end
        if (captured.divide_by_zero !== entry.expected.divide_by_zero) begin
            report_mismatch(where, "divide_by_zero", 32'(captured.divide_by_zero),
                            32'(entry.expected.divide_by_zero));
        end

        // back-pressure, other operands are offered and must be ignored
        for (int i = 0; i < int'(entry.stall); i++) begin
            @(posedge clock);
            in_valid <= 1'b1;
            operands <= '{dividend: ~entry.dividend, divisor: ~entry.divisor};
            @(negedge clock);
            if (!out_valid || in_ready) begin
                report_failure(index, "handshake outputs moved under back-pressure");
            end
            if (result !== captured) begin
                report_mismatch(where, "result", 32'(result), 32'(captured));
            end
        end

        // take the result, handshake on the second edge
        @(posedge clock);
        out_ready <= 1'b1;
        @(posedge clock);
        out_ready <= 1'b0;
        in_valid  <= 1'b0;
        @(negedge clock);
        if (out_valid || !in_ready) begin
            report_failure(index, "divider did not return to the load state after the result");
        end

        if (error_count == errors_before) begin
            pass_count++;
        end else begin
            fail_count++;
        end
        $display("test %0d: %0d / %0d -> q %0d r %0d dbz %0b stall %0d %s", index,
                 $signed(entry.dividend), $signed(entry.divisor), $signed(captured.quotient),
                 $signed(captured.remainder), captured.divide_by_zero, entry.stall,
                 (error_count == errors_before) ? "ok" : "FAILED");
    endtask

    initial begin
        reset       <= 1'b1;
        in_valid    <= 1'b0;
        out_ready   <= 1'b0;
        operands    <= '0;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        lfsr_state  = 32'h8efd_3446;
        table_built = 1'b0;
        build_table();
        table_built = 1'b1;

        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        if (in_ready !== 1'b1) begin
            report_mismatch("reset", "in_ready", 32'(in_ready), 32'h1);
        end
        if (out_valid !== 1'b0) begin
            report_mismatch("reset", "out_valid", 32'(out_valid), 32'h0);
        end
        $display("reset: in_ready %0b out_valid %0b", in_ready, out_valid);

        for (int i = 0; i < test_table.size(); i++) begin
            run_test(i);
        end

        $display("tests %0d passed %0d failed %0d errors %0d",
                 test_table.size(), pass_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // run length follows from the table size
    initial begin
        int limit;
        wait (table_built === 1'b1);
        limit = test_table.size() * TEST_CYCLES + RESET_CYCLES + SPARE_CYCLES;
        repeat (limit) @(posedge clock);
        $display("timeout: the tests did not finish within %0d clock cycles", limit);
        $display("Regression failed");
        $finish;
    end

endmodule
